//--- sim.f
hdl/icache_pkg.sv
hdl/fetch_pkg.sv
hdl/icache_ifs.sv
hdl/icache_tag_stage.sv
hdl/icache_hit_stage.sv
hdl/icache_data_stage.sv
hdl/icache_top.sv
verif/fetch_ref.sv
verif/icache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module icache_tb -f sim.f -o icache_sim
out=$(./obj_dir/icache_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q "^All checks passed$"

//--- verif/icache_tb.sv
`default_nettype none

module icache_tb import icache_pkg::*, fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          credits = 4;
    localparam logic [31:0] seed    = 32'h6929;

    logic    clk           = 1'b0;
    logic    rst_n;
    logic    fetch_valid;
    addr_t   fetch_pc;
    logic    fetch_ready;
    logic    cacop_valid;
    addr_t   cacop_addr;
    logic    l2_req;
    addr_t   l2_addr;
    logic    l2_ack        = 1'b0;
    line_t   l2_data       = '0;
    logic    inst_valid;
    addr_t   inst_pc;
    packet_t inst_data;
    logic    credit_return = 1'b0;
    logic    ref_hit;

    addr_t       exp_q[$];              // fetch pcs in acceptance order
    addr_t       miss_q[$];             // line addresses expected on L2
    logic [31:0] rng        = seed;
    logic [31:0] l2_rng     = seed;
    int          l2_cnt     = 0;
    int          pending    = 0;        // packets not yet given back
    int          held       = 0;        // credits held by decode
    int          cycle      = 0;
    int          hold_until = 0;

    always #10 clk = ~clk;

    icache_top #(.fetch_credits(credits)) dut0 (.*);

    fetch_ref ref0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .look_en  (fetch_valid && fetch_ready),
        .look_pc  (fetch_pc),
        .inv_en   (cacop_valid),
        .inv_addr (cacop_addr),
        .hit      (ref_hit)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    // small tag and set range so that hits and evictions both happen
    function automatic addr_t pc_from(input logic [31:0] r);
        return {17'd0, r[26:24], 4'd0, r[17:16], r[13:10], 2'b00};
    endfunction

    function automatic logic [31:0] word_of(input addr_t a);
        return a ^ 32'h5A5A_0000;
    endfunction

    function automatic line_t l2_line(input addr_t base);
        line_t l;
        for (int i = 0; i < 16; i++) begin
            l[i*32 +: 32] = word_of(base + addr_t'(i * 4));
        end
        return l;
    endfunction

    function automatic packet_t expected_packet(input addr_t pc);
        packet_t p;
        for (int i = 0; i < 4; i++) begin
            p[i] = word_of({pc[31:4], 4'h0} + addr_t'(i * 4));
        end
        return p;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fail_value(input string msg);
        stop_run($sformatf("** Error at %0t ns: %s", $time, msg));
    endtask

    task automatic fetch(input addr_t pc);
        int n;
        n = 0;
        fetch_valid <= 1'b1;
        fetch_pc    <= pc;
        do begin
            @(posedge clk);
            n++;
            if (n > 200) stop_run("timeout: a fetch was never accepted");
        end while (!fetch_ready);
    endtask

    task automatic drain();
        int n;
        n = 0;
        fetch_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 300) stop_run("timeout: fetched packets did not all arrive");
        end
        assert (miss_q.size() == 0) else fail_value("predicted miss sent no L2 request");
    endtask

    task automatic invalidate(input addr_t a);
        cacop_valid <= 1'b1;
        cacop_addr  <= a;
        @(posedge clk);
        cacop_valid <= 1'b0;
    endtask

    // packets come back in acceptance order
    always @(posedge clk) begin
        if (rst_n && fetch_valid && fetch_ready) begin
            exp_q.push_back(fetch_pc);
            if (!ref_hit) begin
                miss_q.push_back({fetch_pc[31:6], 6'd0});
            end
        end
        if (rst_n && inst_valid) begin
            assert (exp_q.size() > 0) else fail_value("packet without an open fetch");
            assert (inst_pc == exp_q[0])
                else fail_value($sformatf("inst_pc %h, expected %h", inst_pc, exp_q[0]));
            assert (inst_data == expected_packet(inst_pc))
                else fail_value($sformatf("inst_data wrong for pc %h", inst_pc));
            void'(exp_q.pop_front());
        end
    end

    // L2 model
    always @(posedge clk) begin
        l2_ack <= 1'b0;
        if (rst_n && l2_req && !l2_ack) begin
            if (l2_cnt == 0) begin
                assert (miss_q.size() > 0 && l2_addr == miss_q[0])
                    else fail_value($sformatf("unexpected L2 request for %h", l2_addr));
                void'(miss_q.pop_front());
                l2_rng <= lcg_next(l2_rng);
                l2_cnt <= 1 + int'(l2_rng[18:16]) % 6;
            end else if (l2_cnt == 1) begin
                l2_ack  <= 1'b1;
                l2_data <= l2_line(l2_addr);
                l2_cnt  <= 0;
            end else begin
                l2_cnt <= l2_cnt - 1;
            end
        end
    end

    // decode gives a credit back per packet once the hold is over
    always @(posedge clk) begin : downstream
        int   p;
        logic ret;
        p   = pending + int'(inst_valid);
        ret = rst_n && p > 0 && cycle >= hold_until;
        credit_return <= ret;
        pending       <= p - int'(ret);
        held          <= held + int'(inst_valid) - int'(credit_return);
        cycle         <= cycle + 1;
    end

    a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
        (fetch_ready && !l2_req && !inst_valid))
        else fail_value("outputs not idle after reset");
    a_line_addr: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req |-> (l2_addr[5:0] == 6'd0))
        else fail_value("l2_addr not line aligned");
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (l2_req && !l2_ack) |=> (l2_req && $stable(l2_addr)))
        else fail_value("l2_req dropped or l2_addr moved before l2_ack");
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        held <= credits)
        else fail_value("more packets delivered than decode has slots");

    initial begin
        addr_t base;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        cacop_valid = 1'b0;
        cacop_addr  = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        base = {20'h12345, 6'h05, 6'h00};   // first bank misses and the rest hit
        for (int b = 0; b < 4; b++) begin
            fetch(base + addr_t'(b * 16 + 4));
        end
        drain();

        repeat (40) begin
            rng = lcg_next(rng);
            fetch(pc_from(rng));
        end
        drain();

        // five tags into set 0x21 and then the same five again
        repeat (2) begin
            for (int t = 0; t < 5; t++) begin
                fetch({20'(32'h300 + t), 6'h21, 6'h10});
            end
        end
        drain();

        invalidate({20'h0, 6'h21, 4'h0, 2'd1});
        for (int t = 0; t < 5; t++) begin
            fetch({20'(32'h300 + t), 6'h21, 6'h20});
        end
        drain();

        hold_until <= cycle + 60;           // decode keeps its credits for a while
        repeat (12) begin
            rng = lcg_next(rng);
            fetch(pc_from(rng));
        end
        drain();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/fetch_ref.sv
`default_nettype none

module fetch_ref import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  look_en,       // fetch accepted on this edge
    input  addr_t look_pc,
    input  logic  inv_en,
    input  addr_t inv_addr,
    output logic  hit
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [num_sets-1:0][num_ways-1:0] vld;
    logic [19:0]                       tags [num_sets][num_ways];
    logic [1:0]                        rr_ptr;   // one pointer for all sets
    logic [5:0]                        set;
    logic [1:0]                        victim;

    assign set = look_pc[11:6];

    always_comb begin
        hit = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (vld[set][w] && tags[set][w] == look_pc[31:12]) begin
                hit = 1'b1;
            end
        end
        if (!vld[set][0]) begin
            victim = 2'd0;
        end else if (!vld[set][1]) begin
            victim = 2'd1;
        end else if (!vld[set][2]) begin
            victim = 2'd2;
        end else if (!vld[set][3]) begin
            victim = 2'd3;
        end else begin
            victim = rr_ptr;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld    <= '0;
            rr_ptr <= 2'd0;
        end else begin
            if (inv_en) begin
                vld[inv_addr[11:6]][inv_addr[1:0]] <= 1'b0;
            end
            if (look_en && !hit) begin
                vld[set][victim]  <= 1'b1;
                tags[set][victim] <= look_pc[31:12];
                if (vld[set] == 4'hf) begin
                    rr_ptr <= rr_ptr + 2'd1;    // refill into a full set
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/icache_top.sv
`default_nettype none

module icache_top import icache_pkg::*, fetch_pkg::*; #(
    parameter int fetch_credits = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    fetch_valid,
    input  addr_t   fetch_pc,
    output logic    fetch_ready,
    input  logic    cacop_valid,
    input  addr_t   cacop_addr,      // bits 1:0 pick the way
    output logic    l2_req,
    output addr_t   l2_addr,
    input  logic    l2_ack,
    input  line_t   l2_data,
    output logic    inst_valid,
    output addr_t   inst_pc,
    output packet_t inst_data,
    input  logic    credit_return
);

    lookup_if lk ();
    refill_if rf ();

    logic     item_valid;
    addr_t    item_pc;
    way_idx_t item_way;
    logic     has_credit;

    icache_tag_stage u_tag (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_ready (fetch_ready),
        .cacop_valid (cacop_valid),
        .cacop_addr  (cacop_addr),
        .lk          (lk.source),
        .rf          (rf.sink)
    );

    icache_hit_stage u_hit (
        .clk        (clk),
        .rst_n      (rst_n),
        .lk         (lk.sink),
        .rf         (rf.source),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr),
        .l2_ack     (l2_ack),
        .l2_data    (l2_data),
        .item_valid (item_valid),
        .item_pc    (item_pc),
        .item_way   (item_way),
        .has_credit (has_credit)
    );

    icache_data_stage #(
        .fetch_credits (fetch_credits)
    ) u_data (
        .clk           (clk),
        .rst_n         (rst_n),
        .item_valid    (item_valid),
        .item_pc       (item_pc),
        .item_way      (item_way),
        .rf            (rf.sink),
        .has_credit    (has_credit),
        .inst_valid    (inst_valid),
        .inst_pc       (inst_pc),
        .inst_data     (inst_data),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

//--- hdl/icache_data_stage.sv
`default_nettype none

module icache_data_stage import icache_pkg::*, fetch_pkg::*; #(
    parameter int fetch_credits = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     item_valid,
    input  addr_t    item_pc,
    input  way_idx_t item_way,
    refill_if.sink   rf,
    output logic     has_credit,
    output logic     inst_valid,
    output addr_t    inst_pc,
    output packet_t  inst_data,
    input  logic     credit_return
);

    logic [bank_bits-1:0] bank_mem [num_sets][num_ways][num_banks];

    set_idx_t             rf_set;
    set_idx_t             item_set;
    bank_idx_t            item_bank;
    logic [bank_bits-1:0] rd_bank;
    credit_t              credit_q;

    assign rf_set    = addr_set(rf.pc);
    assign item_set  = addr_set(item_pc);
    assign item_bank = addr_bank(item_pc);

    always_ff @(posedge clk) begin
        if (rf.we) begin
            for (int b = 0; b < num_banks; b++) begin
                bank_mem[rf_set][rf.way][b] <= rf.line[b*bank_bits +: bank_bits];
            end
        end
    end

    // miss data comes straight off the L2 line
    assign rd_bank = rf.we ? rf.line[item_bank*bank_bits +: bank_bits]
                           : bank_mem[item_set][item_way][item_bank];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= item_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (item_valid) begin
            inst_pc   <= item_pc;
            inst_data <= packet_t'(rd_bank);
        end
    end

    // charged when the item is issued, one cycle ahead of inst_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= credit_t'(fetch_credits);
        end else begin
            credit_q <= credit_q + credit_t'(credit_return) - credit_t'(item_valid);
        end
    end

    assign has_credit = credit_q > credit_t'(item_valid);   // counts the item in flight

endmodule

`default_nettype wire

//--- hdl/icache_hit_stage.sv
`default_nettype none

module icache_hit_stage import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    lookup_if.sink    lk,
    refill_if.source  rf,
    output logic      l2_req,
    output addr_t     l2_addr,
    input  logic      l2_ack,
    input  line_t     l2_data,
    output logic      item_valid,
    output addr_t     item_pc,
    output way_idx_t  item_way,
    input  logic      has_credit
);

    typedef enum logic {
        st_idle,
        st_wait_l2
    } state_t;

    state_t              state_q;
    state_t              state_d;
    logic [num_ways-1:0] hit_vec;
    logic                hit;
    way_idx_t            hit_way;
    logic                set_full;
    way_idx_t            victim;
    way_idx_t            rr_ptr;
    logic                hit_go;
    logic                refill_go;

    logic                item_q_valid;
    addr_t               item_q_pc;
    way_idx_t            item_q_way;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] = lk.vbits[w] && (lk.tags[w] == addr_tag(lk.pc));
            if (hit_vec[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign hit      = |hit_vec;
    assign set_full = &lk.vbits;

    always_comb begin
        victim = rr_ptr;                // all ways taken
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!lk.vbits[w]) begin
                victim = way_idx_t'(w); // lowest free way
            end
        end
    end

    assign hit_go    = lk.valid && (state_q == st_idle) && hit && has_credit;
    assign refill_go = (state_q == st_wait_l2) && l2_ack;
    assign lk.stall  = lk.valid && !hit_go && !refill_go;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                // the slot is reserved before L2 is asked
                if (lk.valid && !hit && has_credit) begin
                    state_d = st_wait_l2;
                end
            end
            st_wait_l2: begin
                if (l2_ack) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (rf.we && set_full) begin
            rr_ptr <= rr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            item_q_valid <= 1'b0;
        end else begin
            item_q_valid <= hit_go;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_go) begin
            item_q_pc  <= lk.pc;
            item_q_way <= hit_way;
        end
    end

    // a refilled item bypasses the hit register
    assign item_valid = item_q_valid || refill_go;
    assign item_pc    = refill_go ? lk.pc : item_q_pc;
    assign item_way   = refill_go ? victim : item_q_way;

    assign l2_req  = (state_q == st_wait_l2);
    assign l2_addr = line_base(lk.pc);     // held by stall

    assign rf.we   = refill_go;
    assign rf.way  = victim;
    assign rf.pc   = lk.pc;
    assign rf.line = l2_data;

endmodule

`default_nettype wire

//--- hdl/icache_tag_stage.sv
`default_nettype none

module icache_tag_stage import icache_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_valid,
    input  addr_t    fetch_pc,
    output logic     fetch_ready,
    input  logic     cacop_valid,
    input  addr_t    cacop_addr,
    lookup_if.source lk,
    refill_if.sink   rf
);

    logic [num_sets-1:0][num_ways-1:0] valid_q;
    tag_t                              tag_mem [num_sets][num_ways];

    set_idx_t            fetch_set;
    set_idx_t            inv_set;
    way_idx_t            inv_way;
    set_idx_t            rf_set;
    tag_t [num_ways-1:0] rd_tags;
    logic [num_ways-1:0] rd_vbits;
    logic                accept;

    logic                s1_valid;
    addr_t               s1_pc;
    tag_t [num_ways-1:0] s1_tags;
    logic [num_ways-1:0] s1_vbits;

    assign fetch_ready = !lk.stall && !cacop_valid;    // invalidate wins
    assign accept      = fetch_valid && fetch_ready;

    assign fetch_set = addr_set(fetch_pc);
    assign inv_set   = addr_set(cacop_addr);
    assign inv_way   = cacop_addr[$bits(way_idx_t)-1:0];
    assign rf_set    = addr_set(rf.pc);

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            rd_tags[w]  = tag_mem[fetch_set][w];
            rd_vbits[w] = valid_q[fetch_set][w];
        end
        // a refill into the same set lands on this edge, so take it directly
        if (rf.we && (rf_set == fetch_set)) begin
            rd_tags[rf.way]  = addr_tag(rf.pc);
            rd_vbits[rf.way] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            if (cacop_valid) begin
                valid_q[inv_set][inv_way] <= 1'b0;     // index invalidate
            end
            if (rf.we) begin
                valid_q[rf_set][rf.way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rf.we) begin
            tag_mem[rf_set][rf.way] <= addr_tag(rf.pc);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (!lk.stall) begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_pc    <= fetch_pc;
            s1_tags  <= rd_tags;
            s1_vbits <= rd_vbits;
        end
    end

    assign lk.valid = s1_valid;
    assign lk.pc    = s1_pc;
    assign lk.tags  = s1_tags;
    assign lk.vbits = s1_vbits;

endmodule

`default_nettype wire

//--- hdl/icache_ifs.sv
`default_nettype none

interface lookup_if import icache_pkg::*; ();

    logic                valid;
    addr_t               pc;
    tag_t [num_ways-1:0] tags;     // snapshot of the fetch set
    logic [num_ways-1:0] vbits;
    logic                stall;    // hit stage holds stage 1

    modport source (
        output valid, pc, tags, vbits,
        input  stall
    );

    modport sink (
        input  valid, pc, tags, vbits,
        output stall
    );

endinterface

interface refill_if import icache_pkg::*; ();

    logic     we;      // one cycle with l2_ack
    way_idx_t way;
    addr_t    pc;
    line_t    line;

    modport source (
        output we, way, pc, line
    );

    modport sink (
        input  we, way, pc, line
    );

endinterface

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int insts_per_packet = 4;

    typedef logic [31:0] inst_t;

    // instruction 0 sits in the low word
    typedef inst_t [insts_per_packet-1:0] packet_t;

    // downstream slot count up to 15
    typedef logic [3:0] credit_t;

endpackage

`default_nettype wire

//--- hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    parameter int num_ways   = 4;
    parameter int num_sets   = 64;
    parameter int line_bytes = 64;
    parameter int bank_bits  = 128;     // one fetch packet

    localparam int offset_bits = $clog2(line_bytes);
    localparam int set_bits    = $clog2(num_sets);
    localparam int num_banks   = line_bytes * 8 / bank_bits;

    typedef logic [31:0]                         addr_t;
    typedef logic [31-offset_bits-set_bits:0]    tag_t;      // pc[31:12]
    typedef logic [set_bits-1:0]                 set_idx_t;  // pc[11:6]
    typedef logic [$clog2(num_ways)-1:0]         way_idx_t;
    typedef logic [$clog2(num_banks)-1:0]        bank_idx_t; // pc[5:4]
    typedef logic [line_bytes*8-1:0]             line_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[31 -: $bits(tag_t)];
    endfunction

    function automatic set_idx_t addr_set(addr_t a);
        return a[offset_bits +: set_bits];
    endfunction

    function automatic bank_idx_t addr_bank(addr_t a);
        return a[offset_bits-1 -: $bits(bank_idx_t)];
    endfunction

    function automatic addr_t line_base(addr_t a);
        return {a[31:offset_bits], {offset_bits{1'b0}}};
    endfunction

endpackage

`default_nettype wire
